/* logic/mult_pkg.sv */
`default_nettype none

package mult_pkg;

    localparam int OPERAND_W  = 16;
    localparam int PRODUCT_W  = 32;
    localparam int NUM_PP     = OPERAND_W;   // One partial product per bit of a

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam int WB_ADR_W = 2;
    localparam int WB_DAT_W = 32;

    // Word addresses
    localparam logic [WB_ADR_W-1:0] ADDR_OPERANDS = 2'd0;
    localparam logic [WB_ADR_W-1:0] ADDR_RESULT   = 2'd1;
    localparam logic [WB_ADR_W-1:0] ADDR_STATUS   = 2'd2;

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [PRODUCT_W-1:0] product_t;

    // Same layout as the bus write word
    typedef struct packed {
        operand_t a;   // Bits 31:16
        operand_t b;   // Bits 15:0
    } operand_pair_t;

    typedef struct packed {
        logic [WB_DAT_W-3:0] reserved;
        logic                operand_full;
        logic                result_ready;   // Result buffer not empty
    } status_t;

    // Ripple of generate/propagate terms, carry in is zero
    function automatic product_t cla_add(input product_t x, input product_t y);
        product_t g;
        product_t p;
        product_t c;
        g    = x & y;
        p    = x ^ y;
        c[0] = 1'b0;
        for (int i = 0; i < PRODUCT_W - 1; i++) begin
            c[i+1] = g[i] | (p[i] & c[i]);
        end
        return p ^ c;
    endfunction

endpackage

`default_nettype wire

/* logic/fifo_if.sv */
`default_nettype none

interface fifo_if #(
    parameter type payload_t = logic
);

    logic     push;
    payload_t wdata;
    logic     full;
    logic     pop;
    payload_t rdata;   // Head entry, valid while empty is low
    logic     empty;

    modport producer (output push, output wdata, input full);
    modport consumer (output pop, input rdata, input empty);

    // Buffer side of the same signals
    modport wr_side (input push, input wdata, output full);
    modport rd_side (input pop, output rdata, output empty);

endinterface

`default_nettype wire

/* logic/sync_fifo.sv */
`default_nettype none

module sync_fifo
    import mult_pkg::*;
#(
    parameter type payload_t = product_t
) (
    input  logic     clk,
    input  logic     rst,
    fifo_if.wr_side  wr,
    fifo_if.rd_side  rd
);

    payload_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;

    function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
        return (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr.full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign rd.empty = (count == '0);
    assign rd.rdata = mem[rd_ptr];   // Fall-through head

    always_ff @(posedge clk) begin
        if (wr.push) begin
            mem[wr_ptr] <= wr.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr.push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd.pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr.push, rd.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle or push with pop
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/mult_pipeline.sv */
`default_nettype none

module mult_pipeline
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    fifo_if.consumer op,
    fifo_if.producer res
);

    product_t pp       [NUM_PP];
    product_t s1_sum_d [NUM_PP/2];
    product_t s1_sum   [NUM_PP/2];
    product_t s2_mid   [NUM_PP/4];
    product_t s2_sum_d [NUM_PP/8];
    product_t s2_sum   [NUM_PP/8];
    product_t s3_sum;

    logic v1;
    logic v2;
    logic v3;
    logic stall;
    logic take;

    // Whole pipe freezes when the last stage cannot drain
    assign stall = v3 & res.full;
    assign take  = ~op.empty & ~stall;

    assign op.pop    = take;
    assign res.push  = v3 & ~res.full;
    assign res.wdata = s3_sum;

    // Stage 1: AND-gated partial products, shifted into place, added in pairs
    always_comb begin
        for (int i = 0; i < NUM_PP; i++) begin
            pp[i] = op.rdata.a[i] ? (product_t'(op.rdata.b) << i) : '0;
        end
        for (int k = 0; k < NUM_PP/2; k++) begin
            s1_sum_d[k] = cla_add(pp[2*k], pp[2*k+1]);
        end
    end

    // Stage 2: eight sums down to two
    always_comb begin
        for (int k = 0; k < NUM_PP/4; k++) begin
            s2_mid[k] = cla_add(s1_sum[2*k], s1_sum[2*k+1]);
        end
        for (int k = 0; k < NUM_PP/8; k++) begin
            s2_sum_d[k] = cla_add(s2_mid[2*k], s2_mid[2*k+1]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else if (!stall) begin
            v1 <= take;
            v2 <= v1;
            v3 <= v2;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_sum <= s1_sum_d;
            s2_sum <= s2_sum_d;
            s3_sum <= cla_add(s2_sum[0], s2_sum[1]);   // Stage 3, final product
        end
    end

endmodule

`default_nettype wire

/* logic/wb_mult_regs.sv */
`default_nettype none

module wb_mult_regs
    import mult_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack,
    fifo_if.producer            op,
    fifo_if.consumer            res
);

    logic    req;
    logic    op_write;
    logic    res_read;
    status_t status;

    // New request, masked during its own ack cycle
    assign req      = wb_cyc & wb_stb & ~wb_ack;
    assign op_write = req & wb_we & (wb_adr == ADDR_OPERANDS);
    assign res_read = req & ~wb_we & (wb_adr == ADDR_RESULT);

    always_comb begin
        status              = '0;
        status.result_ready = ~res.empty;
        status.operand_full = op.full;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack  <= 1'b0;
            op.push <= 1'b0;
            res.pop <= 1'b0;
        end else begin
            wb_ack  <= req & ~(op_write & op.full);   // Stall the master while full
            op.push <= op_write & ~op.full;
            res.pop <= res_read & ~res.empty;
        end
    end

    // Head of res_q cannot change before the pop, so sample it here
    always_ff @(posedge clk) begin
        if (op_write) begin
            op.wdata <= operand_pair_t'(wb_dat_w);
        end
        if (req & ~wb_we) begin
            case (wb_adr)
                ADDR_RESULT: wb_dat_r <= res.empty ? '0 : WB_DAT_W'(res.rdata);
                ADDR_STATUS: wb_dat_r <= WB_DAT_W'(status);
                default:     wb_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/mult16_wb_top.sv */
`default_nettype none

module mult16_wb_top
    import mult_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack
);

    fifo_if #(.payload_t(operand_pair_t)) op_q ();
    fifo_if #(.payload_t(product_t))      res_q ();

    // Operand pairs from the bus
    sync_fifo #(
        .payload_t (operand_pair_t)
    ) u_op_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (op_q.wr_side),
        .rd  (op_q.rd_side)
    );

    sync_fifo #(
        .payload_t (product_t)
    ) u_res_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (res_q.wr_side),
        .rd  (res_q.rd_side)
    );

    mult_pipeline u_mult_pipeline (
        .clk (clk),
        .rst (rst),
        .op  (op_q.consumer),
        .res (res_q.producer)
    );

    wb_mult_regs u_wb_mult_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .op       (op_q.producer),
        .res      (res_q.consumer)
    );

endmodule

`default_nettype wire

/* sim/mult16_checker.sv */
`default_nettype none

module mult16_checker (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic op_push,
    input logic op_full
);

    timeunit 1ns;
    timeprecision 100ps;

    // Classic ack is a one-cycle pulse
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst) wb_ack |=> !wb_ack
    ) else $error("wb_ack high for two cycles in a row");

    ack_after_request: assert property (
        @(posedge clk) disable iff (rst) wb_ack |-> $past(wb_cyc && wb_stb)
    ) else $error("wb_ack without cyc and stb in the previous cycle");

    no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) op_push |-> !op_full
    ) else $error("operand push while the operand buffer is full");

endmodule

bind wb_mult_regs mult16_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .op_push (op.push),
    .op_full (op.full)
);

`default_nettype wire

/* sim/tb_mult16.sv */
`default_nettype none

module tb_mult16
    import mult_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic                clk = 1'b0;
    logic                rst;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_dat_w;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                wb_ack;

    operand_t vec_a [$];
    operand_t vec_b [$];
    product_t vec_p [$];
    product_t expect_q [$];   // Products still owed, oldest first

    int seed           = 90182;
    int pass_checks    = 0;
    int fail_checks    = 0;
    int cycle_count    = 0;
    int timeout_cycles = 1000000;

    mult16_wb_top u_mult16_wb_top (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // One bus cycle, a max_cycles of 0 waits for ack without limit
    task automatic wb_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] dat_w, input int max_cycles,
                            output logic acked, output logic [WB_DAT_W-1:0] dat_r);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat_w;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack && (max_cycles == 0 || waited < max_cycles));
        acked  = wb_ack;
        dat_r  = wb_dat_r;   // Value held during the ack cycle
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        logic                acked;
        logic [WB_DAT_W-1:0] unused;
        wb_cycle(1'b1, adr, dat, 0, acked, unused);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] dat);
        logic acked;
        wb_cycle(1'b0, adr, '0, 0, acked, dat);
    endtask

    task automatic check_product(input string name, input product_t got, input product_t exp);
        if (got === exp) begin
            pass_checks++;
        end else begin
            fail_checks++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input status_t got, input status_t exp);
        if (got === exp) begin
            pass_checks++;
        end else begin
            fail_checks++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    function automatic status_t make_status(input logic ready, input logic full);
        status_t st;
        st              = '0;
        st.result_ready = ready;
        st.operand_full = full;
        return st;
    endfunction

    function automatic logic [WB_DAT_W-1:0] pair_word(input operand_t a, input operand_t b);
        operand_pair_t p;
        p.a = a;
        p.b = b;
        return WB_DAT_W'(p);
    endfunction

    task automatic read_status(output status_t st);
        logic [WB_DAT_W-1:0] d;
        wb_read(ADDR_STATUS, d);
        st = status_t'(d);
    endtask

    task automatic read_product(output product_t p);
        logic [WB_DAT_W-1:0] d;
        wb_read(ADDR_RESULT, d);
        p = product_t'(d);
    endtask

    task automatic read_next_result();
        status_t  st;
        product_t got;
        product_t exp;
        exp = expect_q.pop_front();
        do begin
            read_status(st);
        end while (!st.result_ready);
        read_product(got);
        check_product("wb_dat_r (result)", got, exp);
    endtask

    // Retries a held-back write, draining one result after each refusal
    task automatic push_pair(input operand_t a, input operand_t b, inout int stalls);
        logic                acked;
        logic [WB_DAT_W-1:0] unused;
        status_t             st;
        acked = 1'b0;
        while (!acked) begin
            wb_cycle(1'b1, ADDR_OPERANDS, pair_word(a, b), 16, acked, unused);
            if (!acked) begin
                stalls++;
                read_status(st);   // Pipe is frozen, both flags up
                check_status("wb_dat_r (status)", st, make_status(1'b1, 1'b1));
                if (expect_q.size() > 0) begin
                    read_next_result();
                end
            end
        end
        expect_q.push_back(product_t'(a) * product_t'(b));
    endtask

    task automatic read_vectors();
        int       fd;
        int       n;
        int       r;
        string    line;
        operand_t va;
        operand_t vb;
        product_t vp;
        fd = $fopen("sim/mult_input.txt", "r");
        if (fd == 0) begin
            fail_checks++;
            $display("Could not open the vector file sim/mult_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = 0;
                r    = $fgets(line, fd);
                if (r > 0) begin
                    n = $sscanf(line, "%h %h %h", va, vb, vp);   // Comment lines give 0
                end
                if (n == 3) begin
                    vec_a.push_back(va);
                    vec_b.push_back(vb);
                    vec_p.push_back(vp);
                end
            end
            $fclose(fd);
            if (vec_a.size() == 0) begin
                fail_checks++;
                $display("The vector file holds no usable vectors");
            end
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s: %0d errors", name, fail_checks - fails_before);
    endtask

    task automatic run_tests();
        int       fails_before;
        int       stalls;
        operand_t a;
        operand_t b;
        product_t got;
        status_t  st;

        fails_before = fail_checks;
        for (int i = 0; i < vec_a.size(); i++) begin
            wb_write(ADDR_OPERANDS, pair_word(vec_a[i], vec_b[i]));
            expect_q.push_back(vec_p[i]);
            read_next_result();
        end
        report_test("file_vectors", fails_before);

        // Twelve pairs exceed what the buffers and pipe can hold
        fails_before = fail_checks;
        stalls       = 0;
        for (int i = 0; i < 12; i++) begin
            a = operand_t'($random(seed));
            b = operand_t'($random(seed));
            push_pair(a, b, stalls);
        end
        while (expect_q.size() > 0) begin
            read_next_result();
        end
        if (stalls == 0) begin
            fail_checks++;
            $display("Operand writes were never held back by a full operand buffer");
        end
        report_test("back_pressure", fails_before);

        fails_before = fail_checks;
        read_product(got);
        check_product("wb_dat_r (result)", got, '0);
        read_status(st);
        check_status("wb_dat_r (status)", st, make_status(1'b0, 1'b0));
        report_test("empty_read", fails_before);

        fails_before = fail_checks;
        stalls       = 0;
        for (int i = 0; i < 40; i++) begin
            a = operand_t'($random(seed));
            b = operand_t'($random(seed));
            push_pair(a, b, stalls);
            if (($random(seed) & 1) != 0) begin
                read_next_result();
            end
        end
        while (expect_q.size() > 0) begin
            read_next_result();
        end
        report_test("random_stream", fails_before);

        // Everything drained, so both flags stay low throughout
        fails_before = fail_checks;
        read_status(st);
        check_status("wb_dat_r (status)", st, make_status(1'b0, 1'b0));
        wb_write(ADDR_STATUS, 32'hFFFF_FFFF);
        wb_write(ADDR_RESULT, 32'h1234_5678);
        repeat (8) @(posedge clk);   // Longer than the pipe latency
        read_status(st);
        check_status("wb_dat_r (status)", st, make_status(1'b0, 1'b0));
        read_product(got);
        check_product("wb_dat_r (result)", got, '0);
        report_test("ignored_writes", fails_before);
    endtask

    initial begin
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
        end
        $display("Timeout after %0d clock cycles, the run did not finish", cycle_count);
        $display("tests failed");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        read_vectors();
        // Bus transactions planned: about 4 per vector plus 200 for the other tests
        timeout_cycles = 200 * (4 * vec_a.size() + 200) + 500;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        run_tests();
        $display("checks passed: %0d, checks failed: %0d", pass_checks, fail_checks);
        if (fail_checks == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/mult_input.txt */
# operand_a operand_b expected_product
# all columns in hex
0000 0000 00000000
0000 FFFF 00000000
FFFF 0000 00000000
0001 0001 00000001
0001 FFFF 0000FFFF
FFFF 0001 0000FFFF
FFFF FFFF FFFE0001
0002 0004 00000008
0100 0100 00010000
8000 8000 40000000
8000 0002 00010000
0010 1000 00010000
4000 0004 00010000
1234 5678 06260060
00FF 00FF 0000FE01
FFFF 8000 7FFF8000
ABCD 0003 00020367
0003 0005 0000000F
7FFF 7FFF 3FFF0001

/* vlog.f */
logic/mult_pkg.sv
logic/fifo_if.sv
logic/sync_fifo.sv
logic/mult_pipeline.sv
logic/wb_mult_regs.sv
logic/mult16_wb_top.sv
sim/mult16_checker.sv
sim/tb_mult16.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_mult16 -f vlog.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_mult16)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi

echo "Pass message not found in the simulation output"
exit 1
